// ==== hw/irq_platform_params.svh ====
/*
 * sizes shared by the interrupt front end and its testbench
 * CLKS_PER_BIT must be at least 2 so the mid-bit sample point exists
 * DEBOUNCE_CYCLES must be at least 2 and DATA_W is fixed at 8 for 8N1 framing
 */

`ifndef IRQ_PLATFORM_PARAMS_SVH
`define IRQ_PLATFORM_PARAMS_SVH

// clocks per uart bit, the reference platform runs the line at clk/5
`define CLKS_PER_BIT 5

// synchronized clocks a new button level must hold before it is accepted
`define DEBOUNCE_CYCLES 8

// uart payload bits per frame
`define DATA_W 8

`endif

// ==== hw/irq_platform_pkg.sv ====
/*
 * enum types for the interrupt front end
 * irq_cause_e values are visible on the irq_cause pins and must not be renumbered
 */

package irq_platform_pkg;

    // receiver phases of one 8N1 frame
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0, // waiting for a falling edge on the line
        RX_START = 2'd1, // confirming the start bit at mid-bit
        RX_DATA  = 2'd2, // shifting in data bits, lsb first
        RX_STOP  = 2'd3  // sampling the stop bit
    } rx_state_e;

    // interrupt causes, higher value means higher priority
    typedef enum logic [1:0] {
        CAUSE_NONE     = 2'd0,
        CAUSE_BUTTON   = 2'd1,
        CAUSE_RX_BYTE  = 2'd2,
        CAUSE_RX_ERROR = 2'd3
    } irq_cause_e;

endpackage

// ==== hw/irq_event_if.sv ====
/*
 * single-cycle event bundle from the deframer stage to the interrupt stage
 * every strobe is one clock wide and byte_data is only meaningful with a strobe
 */

`timescale 1ns/1ns
`include "irq_platform_params.svh"

interface irq_event_if;

    logic              byte_valid; // well-framed byte completed
    logic              frame_err;  // stop bit sampled low
    logic [`DATA_W-1:0] byte_data; // payload for either of the two strobes above
    logic              btn_press;  // debounced button press, aligned with the uart strobes

    // producer side drives everything
    modport src (
        output byte_valid, frame_err, byte_data, btn_press
    );

    // interrupt controller only listens
    modport dst (
        input byte_valid, frame_err, byte_data, btn_press
    );

endinterface

// ==== hw/input_sync.sv ====
/*
 * brings uart_rx and btnd into the clk domain through two flops each
 * rx_sync lags the pin by 2 clocks, btn_rise fires DEBOUNCE_CYCLES+2 clocks
 * after a clean press and button pulses shorter than DEBOUNCE_CYCLES are dropped
 */

`timescale 1ns/1ns
`include "irq_platform_params.svh"

module input_sync (
    input  logic clk,
    input  logic arst_n,
    input  logic uart_rx,
    input  logic btnd,
    output logic rx_sync,
    output logic btn_rise
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

    logic             rx_meta;
    logic             btn_meta;
    logic             btn_sync;
    logic             btn_level;  // debounced level the rest of the design trusts
    logic [CNT_W-1:0] stable_cnt; // clocks the synchronized level has differed from btn_level
    logic             accept;

    // the uart line idles high so its flops reset to 1 to avoid a false start bit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            rx_meta  <= uart_rx;
            rx_sync  <= rx_meta;
            btn_meta <= btnd;
            btn_sync <= btn_meta;
        end
    end

    // last clock of a run of differing samples, the new level is taken now
    assign accept = (btn_sync != btn_level) && (stable_cnt == CNT_LAST);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stable_cnt <= '0;
            btn_level  <= 1'b0;
            btn_rise   <= 1'b0;
        end else begin
            btn_rise <= accept && btn_sync; // only a low to high acceptance is a press
            if (btn_sync == btn_level) begin
                stable_cnt <= '0; // bounce back, restart the count
            end else if (accept) begin
                btn_level  <= btn_sync;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // a press must be released and debounced again before another pulse
    btn_rise_single: assert property (@(posedge clk) disable iff (!arst_n)
        btn_rise |=> !btn_rise)
        else $error("btn_rise held high for two cycles");

endmodule

// ==== hw/uart_deframer.sv ====
/*
 * 8N1 receiver on the synchronized line, every bit is sampled CLKS_PER_BIT/2 clocks in
 * returns to idle at the stop-bit sample and needs a high to low edge for the next start
 * so after a frame error the line has to go high first, no parity and no fifo
 */

`timescale 1ns/1ns
`include "irq_platform_params.svh"

module uart_deframer (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     rx_sync,
    input  logic     btn_rise,
    irq_event_if.src ev
);

    localparam int HALF_BIT = `CLKS_PER_BIT / 2;
    localparam int TICK_W   = $clog2(`CLKS_PER_BIT);
    localparam int IDX_W    = $clog2(`DATA_W + 1); // one spare state so the range check means something

    localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(HALF_BIT - 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(`DATA_W - 1);

    irq_platform_pkg::rx_state_e state;

    logic [TICK_W-1:0]  tick;     // clocks since the last sample point
    logic [IDX_W-1:0]   bit_idx;  // data bit being received
    logic [`DATA_W-1:0] shift_q;  // lsb arrives first and ends up in bit 0
    logic               rx_prev;  // line one clock ago for edge detection
    logic               start_edge;
    logic               sample_pt; // full bit time elapsed, take a data or stop sample
    logic               byte_valid_q;
    logic               frame_err_q;
    logic               btn_press_q;

    assign start_edge = rx_prev && !rx_sync;
    assign sample_pt  = (tick == TICK_LAST);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= irq_platform_pkg::RX_IDLE;
            tick         <= '0;
            bit_idx      <= '0;
            rx_prev      <= 1'b1;
            byte_valid_q <= 1'b0;
            frame_err_q  <= 1'b0;
            btn_press_q  <= 1'b0;
        end else begin
            rx_prev      <= rx_sync;
            byte_valid_q <= 1'b0; // strobes default low, set for one clock below
            frame_err_q  <= 1'b0;
            btn_press_q  <= btn_rise; // delayed once to line up with the uart strobes

            case (state)
                irq_platform_pkg::RX_IDLE: begin
                    tick    <= '0;
                    bit_idx <= '0;
                    if (start_edge) begin
                        state <= irq_platform_pkg::RX_START;
                    end
                end

                irq_platform_pkg::RX_START: begin
                    if (tick == TICK_MID) begin
                        tick <= '0;
                        // a line back high at mid-bit was a glitch
                        state <= rx_sync ? irq_platform_pkg::RX_IDLE
                                         : irq_platform_pkg::RX_DATA;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end

                irq_platform_pkg::RX_DATA: begin
                    if (sample_pt) begin
                        tick <= '0;
                        if (bit_idx == IDX_LAST) begin
                            state <= irq_platform_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end

                irq_platform_pkg::RX_STOP: begin
                    if (sample_pt) begin
                        tick         <= '0;
                        byte_valid_q <= rx_sync;  // high stop bit means a good frame
                        frame_err_q  <= !rx_sync;
                        state        <= irq_platform_pkg::RX_IDLE; // edge detect guards the low case
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end

                default: state <= irq_platform_pkg::RX_IDLE;
            endcase
        end
    end

    // payload only, the strobes say when it is valid
    always_ff @(posedge clk) begin
        if (state == irq_platform_pkg::RX_DATA && sample_pt) begin
            shift_q <= {rx_sync, shift_q[`DATA_W-1:1]};
        end
    end

    assign ev.byte_valid = byte_valid_q;
    assign ev.frame_err  = frame_err_q;
    assign ev.byte_data  = shift_q;    // stable from the last data sample until the next frame
    assign ev.btn_press  = btn_press_q;

    // a frame ends either well or badly, never both
    event_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(ev.byte_valid && ev.frame_err))
        else $error("byte_valid and frame_err asserted together");

    bit_idx_range: assert property (@(posedge clk) disable iff (!arst_n)
        bit_idx <= IDX_LAST)
        else $error("bit index %0d past last data bit", bit_idx);

endmodule

// ==== hw/irq_controller.sv ====
/*
 * holds one pending flag per cause, no masking and no overrun reporting
 * priority is RX_ERROR over RX_BYTE over BUTTON, irq_ack clears only the cause shown
 * rx_data is overwritten by every received frame, good or bad
 */

`timescale 1ns/1ns
`include "irq_platform_params.svh"

module irq_controller (
    input  logic               clk,
    input  logic               arst_n,
    irq_event_if.dst           ev,
    input  logic               irq_ack,
    output logic               irq,
    output logic [1:0]         irq_cause,
    output logic [`DATA_W-1:0] rx_data
);

    irq_platform_pkg::irq_cause_e cause;

    logic pend_btn;
    logic pend_byte;
    logic pend_err;
    logic ack_btn;  // acknowledge aimed at the cause shown this cycle
    logic ack_byte;
    logic ack_err;

    // fixed priority encoder over the pending flags
    always_comb begin
        if (pend_err) begin
            cause = irq_platform_pkg::CAUSE_RX_ERROR;
        end else if (pend_byte) begin
            cause = irq_platform_pkg::CAUSE_RX_BYTE;
        end else if (pend_btn) begin
            cause = irq_platform_pkg::CAUSE_BUTTON;
        end else begin
            cause = irq_platform_pkg::CAUSE_NONE;
        end
    end

    assign ack_err  = irq_ack && (cause == irq_platform_pkg::CAUSE_RX_ERROR);
    assign ack_byte = irq_ack && (cause == irq_platform_pkg::CAUSE_RX_BYTE);
    assign ack_btn  = irq_ack && (cause == irq_platform_pkg::CAUSE_BUTTON);

    assign irq       = pend_err || pend_byte || pend_btn;
    assign irq_cause = cause;

    // a fresh event outranks an acknowledge of its own cause in the same clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_err  <= 1'b0;
            pend_byte <= 1'b0;
            pend_btn  <= 1'b0;
        end else begin
            pend_err  <= ev.frame_err  || (pend_err  && !ack_err);
            pend_byte <= ev.byte_valid || (pend_byte && !ack_byte);
            pend_btn  <= ev.btn_press  || (pend_btn  && !ack_btn);
        end
    end

    // data bits of the last frame, zero until the first one arrives
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_data <= '0;
        end else if (ev.byte_valid || ev.frame_err) begin
            rx_data <= ev.byte_data; // bad frames keep their data bits too
        end
    end

    irq_matches_cause: assert property (@(posedge clk) disable iff (!arst_n)
        irq == (irq_cause != irq_platform_pkg::CAUSE_NONE))
        else $error("irq %0b disagrees with irq_cause %0d", irq, irq_cause);

    // the core should only acknowledge something it was shown
    ack_needs_irq: assert property (@(posedge clk) disable iff (!arst_n)
        irq_ack |-> irq)
        else $error("irq_ack while irq is low");

endmodule

// ==== hw/irq_platform_top.sv ====
/*
 * interrupt front end, uart_rx and btnd in, irq with a readable cause out
 * uart_rx and btnd may be fully asynchronous to clk, irq_ack must be a clk-synchronous pulse
 */

`timescale 1ns/1ns
`include "irq_platform_params.svh"

module irq_platform_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               btnd,
    input  logic               uart_rx,
    input  logic               irq_ack,
    output logic               irq,
    output logic [1:0]         irq_cause,
    output logic [`DATA_W-1:0] rx_data
);

    logic rx_sync;  // line level in the clk domain
    logic btn_rise; // one clock per debounced press

    irq_event_if ev_if (); // strobes from the deframer stage to the controller

    input_sync u_input_sync (
        .clk      (clk),
        .arst_n   (arst_n),
        .uart_rx  (uart_rx),
        .btnd     (btnd),
        .rx_sync  (rx_sync),
        .btn_rise (btn_rise)
    );

    uart_deframer u_uart_deframer (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_sync  (rx_sync),
        .btn_rise (btn_rise),
        .ev       (ev_if.src)
    );

    irq_controller u_irq_controller (
        .clk       (clk),
        .arst_n    (arst_n),
        .ev        (ev_if.dst),
        .irq_ack   (irq_ack),
        .irq       (irq),
        .irq_cause (irq_cause),
        .rx_data   (rx_data)
    );

endmodule

// ==== verification/irq_platform_checker.sv ====
/*
 * reference model fed only by the DUT pins, it decodes uart_rx at mid-bit on its own
 * irq lags the model by a few clocks, so causes and rx_data are compared at each irq_ack
 * and irq itself is held against the model's pending set on every clock
 */

`timescale 1ns/1ns
`include "irq_platform_params.svh"

module irq_platform_checker (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               uart_rx,
    input  logic               btnd,
    input  logic               irq_ack,
    input  logic               irq,
    input  logic [1:0]         irq_cause,
    input  logic [`DATA_W-1:0] rx_data,
    input  int                 test_id,
    output int                 error_count,
    output int                 check_count
);

    localparam int CPB = `CLKS_PER_BIT;

    int                 errors = 0;
    int                 checks = 0;
    logic               busy;      // a frame is being decoded
    logic               line_prev; // start needs a high to low step, as on a real line
    int                 pos;       // clocks since the first low sample of the start bit
    logic [`DATA_W-1:0] shreg;
    logic [`DATA_W-1:0] exp_data;  // data bits of the last frame, good or bad
    int                 btn_cnt;   // clocks the button has been high in a row
    logic               pend_err;
    logic               pend_byte;
    logic               pend_btn;
    logic               irq_prev;
    logic               reset_checked;
    logic [1:0]         shown;     // cause the core should see at an acknowledge

    assign error_count = errors;
    assign check_count = checks;

    function automatic string test_name(input int id);
        case (id)
            0: return "reset";
            1: return "rx_byte";
            2: return "rx_frame_err";
            3: return "button";
            4: return "button_glitch";
            5: return "overlap";
            default: return "unknown";
        endcase
    endfunction

    // error outranks a byte, a byte outranks the button
    function automatic logic [1:0] highest(input logic err, input logic byt, input logic btn);
        return err ? irq_platform_pkg::CAUSE_RX_ERROR
             : byt ? irq_platform_pkg::CAUSE_RX_BYTE
             : btn ? irq_platform_pkg::CAUSE_BUTTON : irq_platform_pkg::CAUSE_NONE;
    endfunction

    task automatic expect_value(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("FAIL %s: %s expected 0x%0h actual 0x%0h",
                     test_name(test_id), what, expected, actual);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("ERROR %s: %s", test_name(test_id), what);
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy          = 1'b0;
            line_prev     = 1'b1;
            pos           = 0;
            shreg         = '0;
            exp_data      = '0;
            btn_cnt       = 0;
            pend_err      = 1'b0;
            pend_byte     = 1'b0;
            pend_btn      = 1'b0;
            irq_prev      = 1'b0;
            reset_checked = 1'b0;
        end else begin
            if (!reset_checked) begin // first clock out of reset, nothing driven yet
                expect_value("irq", 0, int'(irq));
                expect_value("irq_cause", 0, int'(irq_cause));
                expect_value("rx_data", 0, int'(rx_data));
                reset_checked = 1'b1;
            end

            // DUT values here are from before this edge, so the model is too
            if (irq && !(pend_err || pend_byte || pend_btn)) begin
                report("irq is high but the model has no cause pending");
            end
            if (irq_prev && !irq && (pend_err || pend_byte || pend_btn)) begin
                report("irq fell while the model still had a cause pending");
            end
            irq_prev = irq;

            if (irq_ack) begin
                shown = highest(pend_err, pend_byte, pend_btn);
                if (shown == irq_platform_pkg::CAUSE_NONE) begin
                    report("irq_ack arrived with nothing pending in the model");
                end else begin
                    expect_value("irq_cause", int'(shown), int'(irq_cause));
                    if (shown != irq_platform_pkg::CAUSE_BUTTON) begin
                        expect_value("rx_data", int'(exp_data), int'(rx_data));
                    end
                end
                pend_err  = pend_err  && (shown != irq_platform_pkg::CAUSE_RX_ERROR);
                pend_byte = pend_byte && (shown != irq_platform_pkg::CAUSE_RX_BYTE);
                pend_btn  = pend_btn  && (shown != irq_platform_pkg::CAUSE_BUTTON);
            end

            // a level held DEBOUNCE_CYCLES clocks counts as one press
            if (!btnd) begin
                btn_cnt = 0;
            end else if (btn_cnt < `DEBOUNCE_CYCLES) begin
                btn_cnt++;
                pend_btn = pend_btn || (btn_cnt == `DEBOUNCE_CYCLES);
            end

            // 8N1 decoder, bit k is taken CPB/2 clocks into it, k=0 is the start bit
            if (!busy) begin
                busy = line_prev && !uart_rx;
                pos  = 1;
            end else begin
                if (pos % CPB == CPB / 2) begin
                    if (pos / CPB == 0) begin
                        busy = !uart_rx; // start bit high again at mid-bit was a glitch
                    end else if (pos / CPB <= `DATA_W) begin
                        shreg = {uart_rx, shreg[`DATA_W-1:1]}; // lsb first on the line
                    end else begin
                        exp_data  = shreg;
                        pend_byte = pend_byte || uart_rx;
                        pend_err  = pend_err || !uart_rx;
                        busy      = 1'b0;
                    end
                end
                pos++;
            end
            line_prev = uart_rx;
        end
    end

endmodule

// ==== verification/irq_platform_tb.sv ====
/*
 * 60 random transactions: good byte, low stop bit, button press and button glitch
 * a press is sometimes followed at once by a byte so two causes overlap
 * inputs change on the falling edge, the checker module compares the outputs
 */

`timescale 1ns/1ns
`include "irq_platform_params.svh"

module irq_platform_tb;

    localparam int N_TRANS  = 60;
    localparam int LONGEST  = 11 * `CLKS_PER_BIT + 2 * `DEBOUNCE_CYCLES + 64;
    localparam int WATCHDOG = N_TRANS * LONGEST * 2; // clocks
    localparam int IRQ_WAIT = 64;
    localparam int MAX_ACKS = 8; // three causes exist, more acks means irq is stuck

    logic               clk;
    logic               arst_n;
    logic               btnd;
    logic               uart_rx;
    logic               irq_ack;
    logic               irq;
    logic [1:0]         irq_cause;
    logic [`DATA_W-1:0] rx_data;
    logic [15:0]        lfsr;
    int                 test_id;   // tells the checker which kind of transaction runs
    int                 tb_errors;
    int                 chk_errors;
    int                 chk_count;

    irq_platform_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .btnd      (btnd),
        .uart_rx   (uart_rx),
        .irq_ack   (irq_ack),
        .irq       (irq),
        .irq_cause (irq_cause),
        .rx_data   (rx_data)
    );

    irq_platform_checker u_check (
        .clk         (clk),
        .arst_n      (arst_n),
        .uart_rx     (uart_rx),
        .btnd        (btnd),
        .irq_ack     (irq_ack),
        .irq         (irq),
        .irq_cause   (irq_cause),
        .rx_data     (rx_data),
        .test_id     (test_id),
        .error_count (chk_errors),
        .check_count (chk_count)
    );

    always #20 clk = ~clk; // 40 ns period

    // fibonacci form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[14:0], lfsr[0]}; // one step per bit taken
        end
    endtask

    // all stimulus tasks start and end right after a falling edge
    task automatic hold_line(input logic level);
        uart_rx = level;
        repeat (`CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_frame(input logic [`DATA_W-1:0] data, input logic stop);
        logic [`DATA_W-1:0] bits;
        int i;
        bits = data;
        hold_line(1'b0);
        for (i = 0; i < `DATA_W; i++) begin
            hold_line(bits[0]);
            bits = bits >> 1;
        end
        hold_line(stop);
        hold_line(1'b1); // idle bit, irq is up by its end and a bad frame is closed high
    endtask

    task automatic press_button(input int len);
        btnd = 1'b1;
        repeat (len) @(negedge clk);
        btnd = 1'b0;
    endtask

    // wait for irq, then acknowledge after 0..7 clocks until it drops
    task automatic serve_irq(input int n);
        int waited;
        int acks;
        logic [15:0] r;
        waited = 0;
        acks   = 0;
        while (!irq && waited < IRQ_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!irq) begin
            tb_errors++;
            $display("irq did not rise within %0d clocks in transaction %0d", IRQ_WAIT, n);
        end
        while (irq && acks < MAX_ACKS) begin
            take_bits(3, r);
            repeat (r[2:0]) @(negedge clk);
            irq_ack = 1'b1;
            @(negedge clk);
            irq_ack = 1'b0;
            acks++;
        end
        if (irq) begin
            tb_errors++;
            $display("irq still high after %0d acknowledges in transaction %0d", acks, n);
        end
    endtask

    initial begin
        logic [15:0] r;
        logic [15:0] d;
        int n;
        clk       = 1'b0;
        arst_n    = 1'b0;
        btnd      = 1'b0;
        uart_rx   = 1'b1;
        irq_ack   = 1'b0;
        lfsr      = 16'd17;
        test_id   = 0;
        tb_errors = 0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk); // checker looks at the reset values here

        for (n = 0; n < N_TRANS; n++) begin
            take_bits(2, r);
            take_bits(`DATA_W, d);
            if (n == 0) begin
                r = 16'd2; // first transaction always forces the overlap
            end
            case (r[1:0])
                2'd0, 2'd1: begin
                    test_id = r[0] ? 2 : 1;
                    send_frame(d[`DATA_W-1:0], !r[0]);
                    serve_irq(n);
                end
                2'd2: begin
                    take_bits(1, r);
                    test_id = (r[0] || n == 0) ? 5 : 3;
                    press_button(2 * `DEBOUNCE_CYCLES);
                    if (test_id == 5) begin
                        send_frame(d[`DATA_W-1:0], 1'b1); // byte lands before any ack
                    end
                    serve_irq(n);
                    repeat (2 * `DEBOUNCE_CYCLES + 2) @(negedge clk); // release debounces
                end
                default: begin
                    test_id = 4;
                    press_button(`DEBOUNCE_CYCLES / 2);
                    repeat (4 * `DEBOUNCE_CYCLES) @(negedge clk); // any irq here is an error
                end
            endcase
        end

        repeat (8) @(negedge clk);
        $display("closing: %0d checks, %0d checker errors, %0d testbench errors",
                 chk_count, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // twice the transaction count times the longest transaction
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d clocks, the run did not finish", WATCHDOG);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/irq_platform_pkg.sv
hw/irq_event_if.sv
hw/input_sync.sv
hw/uart_deframer.sv
hw/irq_controller.sv
hw/irq_platform_top.sv
verification/irq_platform_checker.sv
verification/irq_platform_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := irq_platform_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

# the run counts as passed only when the log holds the pass message
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
